//--- build.f
+incdir+source
source/had_pkg.sv
source/had_cmd_decoder.sv
source/ct_had_sync_3flop.sv
source/had_ctrl_fsm.sv
source/had_status_return.sv
source/had_debug_top.sv
sim/tb_had_debug.sv

//--- sim/tb_had_debug.sv
/*
  testbench for the debug subsystem top level
  clk1 runs at 20 ns, clk2 at 60 ns, so clk2 stays the slower clock
  commands are spaced three clk2 cycles apart
  the core model drains within 9 clk1 cycles and retires freely while not halted
  latencies vary with clock phase, so every wait is bounded, never exact
*/
`timescale 1ns/1ns
`default_nettype none

`include "had_settings.svh"

module tb_had_debug;

  import had_pkg::*;

  // clk2 cycles allowed per command including its wait for the result
  localparam int CMD_BUDGET = 20;
  localparam logic [31:0] LFSR_SEED = 32'h10d2dd9f;
  localparam int WATCH_HALTED = 0;
  localparam int WATCH_CORE_HALT = 1;
  localparam int WATCH_CORE_IDLE = 2;

  logic                       clk1;
  logic                       clk2;
  logic                       rst1_b;
  logic                       rst2_b;
  logic                       cmd_valid = 1'b0;
  logic [`HAD_CMD_W-1:0]      cmd = '0;
  logic                       halted;
  logic [`HAD_STEP_CNT_W-1:0] step_count;
  logic                       cmd_err;
  logic                       core_halt;
  logic                       core_idle = 1'b0;
  logic                       core_retire = 1'b0;

  // reference state kept by the stimulus
  logic [`HAD_STEP_CNT_W-1:0] expected_count = '0;
  logic                       halted_expected = 1'b0;
  logic                       running_check = 1'b0;
  logic [31:0]                lfsr_state = LFSR_SEED;
  int                         mismatch_errors = 0;
  int                         bound_errors = 0;
  int                         cycle_count = 0;
  int                         timeout_limit = 1000000;
  int                         idle_wait = 0;
  int                         retire_wait = 1;
  // retire pulses issued by the core model so far
  int                         retire_total = 0;
  logic                       idle_armed = 1'b0;
  int                         first_burst;
  int                         second_burst;
  int                         bad_op;

  had_debug_top had_debug_top_inst (
    .clk1       (clk1),
    .clk2       (clk2),
    .rst1_b     (rst1_b),
    .rst2_b     (rst2_b),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .halted     (halted),
    .step_count (step_count),
    .cmd_err    (cmd_err),
    .core_halt  (core_halt),
    .core_idle  (core_idle),
    .core_retire(core_retire)
  );

  initial
  begin
    clk1 = 1'b0;
    forever #10 clk1 = ~clk1;
  end

  initial
  begin
    clk2 = 1'b0;
    forever #30 clk2 = ~clk2;
  end

  // ==================================================
  // helpers
  // ==================================================
  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic watched_level(input int sel);
    case (sel)
      WATCH_HALTED:    watched_level = halted;
      WATCH_CORE_HALT: watched_level = core_halt;
      default:         watched_level = core_idle;
    endcase
  endfunction

  // strobe then two idle clk2 cycles so identical commands never merge
  task automatic issue_cmd(input logic [`HAD_CMD_W-1:0] op);
    @(posedge clk2);
    cmd_valid <= 1'b1;
    cmd       <= op;
    @(posedge clk2);
    cmd_valid <= 1'b0;
    cmd       <= cmd_nop;
    @(posedge clk2);
  endtask

  task automatic check_value(input logic ok, input string what);
    assert (ok)
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t: %s", $time, what);
    end
  endtask

  task automatic wait_level(input int sel, input logic level, input int bound,
                            input string what);
    int n;
    n = 0;
    while (watched_level(sel) !== level && n < bound)
    begin
      @(posedge clk2);
      n++;
    end
    assert (watched_level(sel) === level)
    else
    begin
      bound_errors++;
      $display("Timing error at %0t: %s", $time, what);
    end
  endtask

  // a released step reaches the core as one retire pulse
  task automatic wait_retire(input int seen, input int bound);
    int n;
    n = 0;
    while (retire_total == seen && n < bound)
    begin
      @(posedge clk2);
      n++;
    end
    assert (retire_total != seen)
    else
    begin
      bound_errors++;
      $display("Timing error at %0t: no core_retire after the step command", $time);
    end
  endtask

  task automatic wait_step_count(input logic [`HAD_STEP_CNT_W-1:0] expected, input int bound);
    int n;
    n = 0;
    while (step_count !== expected && n < bound)
    begin
      @(posedge clk2);
      n++;
    end
    assert (step_count === expected)
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t: step_count is %0d, expected %0d", $time, step_count, expected);
    end
  endtask

  // each step must be counted within 8 clk2 cycles of its retire
  task automatic run_steps(input int count);
    int retires;
    for (int i = 0; i < count; i++)
    begin
      retires = retire_total;
      issue_cmd(cmd_step);
      expected_count = expected_count + 1'b1;
      wait_retire(retires, 8);
      wait_step_count(expected_count, 8);
    end
  endtask

  task automatic finish_run();
    $display("Checks done: %0d mismatches, %0d timing errors", mismatch_errors, bound_errors);
    if (mismatch_errors + bound_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  // ==================================================
  // core model
  // ==================================================
  always @(posedge clk1)
  begin
    if (!rst1_b)
    begin
      core_idle   <= 1'b0;
      core_retire <= 1'b0;
      idle_armed  = 1'b0;
    end
    else
    begin
      core_retire <= 1'b0;
      if (core_halt)
      begin
        // drain delay drawn once per rising halt
        if (!idle_armed)
        begin
          draw_bits(3, idle_wait);
          idle_armed = 1'b1;
        end
        else if (idle_wait > 0)
          idle_wait = idle_wait - 1;
        else
          core_idle <= 1'b1;
      end
      else
      begin
        core_idle  <= 1'b0;
        idle_armed = 1'b0;
        // retire gaps of 1 to 8 cycles keep pulses apart
        if (retire_wait > 0)
          retire_wait = retire_wait - 1;
        else
        begin
          core_retire  <= 1'b1;
          retire_total <= retire_total + 1;
          draw_bits(3, retire_wait);
          retire_wait = retire_wait + 1;
        end
      end
    end
  end

  // ==================================================
  // concurrent checks
  // ==================================================
  // while parked a released halt waits for exactly one retire
  a_step_waits: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    (halted_expected && !core_halt && !core_retire) |=> !core_halt
  )
  else
  begin
    mismatch_errors++;
    $display("Mismatch at %0t: core_halt rose without a retire", $time);
  end

  a_step_returns: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    (halted_expected && !core_halt && core_retire) |=> core_halt
  )
  else
  begin
    mismatch_errors++;
    $display("Mismatch at %0t: core_halt missing after retire", $time);
  end

  a_err_set: assert property (
    @(posedge clk2) disable iff (!rst2_b)
    $rose(cmd_err) |-> $past(cmd_valid) && ($past(cmd) > 3'd4)
  )
  else
  begin
    mismatch_errors++;
    $display("Mismatch at %0t: cmd_err set by a legal opcode", $time);
  end

  a_err_sticky: assert property (
    @(posedge clk2) disable iff (!rst2_b)
    $fell(cmd_err) |-> $past(cmd_valid) && ($past(cmd) == cmd_clear)
  )
  else
  begin
    mismatch_errors++;
    $display("Mismatch at %0t: cmd_err fell without clear", $time);
  end

  // step and resume while running must leave the status untouched
  a_running_quiet: assert property (
    @(posedge clk2) disable iff (!rst2_b)
    running_check |-> !halted && !core_halt && (step_count == expected_count)
  )
  else
  begin
    mismatch_errors++;
    $display("Mismatch at %0t: status moved while running", $time);
  end

  always @(posedge clk2)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      bound_errors++;
      $display("Timeout: the run did not finish within %0d clk2 cycles", timeout_limit);
      finish_run();
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  initial
  begin
    rst1_b = 1'b0;
    rst2_b = 1'b0;
    // random counts drawn before the core model starts using the lfsr
    draw_bits(4, first_burst);
    first_burst = first_burst + 1;
    draw_bits(4, second_burst);
    second_burst = second_burst + (1 << `HAD_STEP_CNT_W);
    draw_bits(2, bad_op);
    bad_op = 5 + (bad_op % 3);
    // nine commands besides the two step bursts plus the reset cycles
    timeout_limit = 4 * (10 + CMD_BUDGET * (first_burst + second_burst + 9));
    fork
      begin
        repeat (10) @(posedge clk1);
        rst1_b <= 1'b1;
      end
      begin
        repeat (10) @(posedge clk2);
        rst2_b <= 1'b1;
      end
    join
    @(posedge clk2);
    check_value(core_halt === 1'b0 && halted === 1'b0 && cmd_err === 1'b0
                && step_count === '0, "outputs not idle after reset");

    // step and resume while running are dropped
    running_check = 1'b1;
    issue_cmd(cmd_step);
    issue_cmd(cmd_resume);
    repeat (8) @(posedge clk2);
    running_check = 1'b0;

    issue_cmd(cmd_halt);
    wait_level(WATCH_CORE_HALT, 1'b1, 8, "core_halt did not rise after the halt command");
    wait_level(WATCH_CORE_IDLE, 1'b1, 8, "the core model never reported idle");
    wait_level(WATCH_HALTED, 1'b1, 8, "halted did not rise within 8 clk2 cycles of core_idle");
    halted_expected = 1'b1;
    run_steps(first_burst);

    // illegal opcode holds cmd_err until the clear
    issue_cmd(bad_op[`HAD_CMD_W-1:0]);
    check_value(cmd_err === 1'b1, "cmd_err not set by an illegal opcode");
    issue_cmd(cmd_nop);
    check_value(cmd_err === 1'b1, "cmd_err dropped before cmd_clear");
    issue_cmd(cmd_clear);
    check_value(cmd_err === 1'b0, "cmd_err still set after cmd_clear");
    expected_count = '0;
    wait_step_count(expected_count, 4);

    // long enough to wrap the counter
    run_steps(second_burst);

    halted_expected = 1'b0;
    issue_cmd(cmd_resume);
    wait_level(WATCH_HALTED, 1'b0, 8, "halted did not fall after the resume command");
    check_value(core_halt === 1'b0, "core_halt still high after resume");
    running_check = 1'b1;
    issue_cmd(cmd_step);
    issue_cmd(cmd_resume);
    repeat (8) @(posedge clk2);
    running_check = 1'b0;
    finish_run();
  end

endmodule

`default_nettype wire

//--- source/ct_had_sync_3flop.sv
/*
  pulse synchronizer from clk2 to clk1
  valid only when clk2 is the slower clock
  two identical pulses back to back in clk2 merge into one
  output pulse appears 3 to 4 clk1 cycles after the clk2 flop
*/
`timescale 1ns/1ns
`default_nettype none

module ct_had_sync_3flop (
  input  logic clk1,
  input  logic clk2,
  input  logic rst1_b,
  input  logic rst2_b,
  input  logic sync_in,
  output logic sync_out
);

  logic sync_ff_clk2;
  logic sync_ff1_clk1;
  logic sync_ff2_clk1;
  logic sync_ff3_clk1;
  logic sync_ff4_clk1;

  // ==================================================
  // launch flop in the slow domain
  // ==================================================
  always_ff @(posedge clk2 or negedge rst2_b)
  begin
    if (!rst2_b)
      sync_ff_clk2 <= 1'b0;
    else
      sync_ff_clk2 <= sync_in;
  end

  // ==================================================
  // capture chain in the fast domain
  // ==================================================
  // ff1 and ff2 settle metastability, ff3 and ff4 form the edge detector
  always_ff @(posedge clk1 or negedge rst1_b)
  begin
    if (!rst1_b)
    begin
      sync_ff1_clk1 <= 1'b0;
      sync_ff2_clk1 <= 1'b0;
      sync_ff3_clk1 <= 1'b0;
      sync_ff4_clk1 <= 1'b0;
    end
    else
    begin
      sync_ff1_clk1 <= sync_ff_clk2;
      sync_ff2_clk1 <= sync_ff1_clk1;
      sync_ff3_clk1 <= sync_ff2_clk1;
      sync_ff4_clk1 <= sync_ff3_clk1;
    end
  end

  // rising edge of the synchronized level, one clk1 cycle wide
  assign sync_out = sync_ff3_clk1 && !sync_ff4_clk1;

  a_pulse_width: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    sync_out |=> !sync_out
  );

endmodule

`default_nettype wire

//--- source/had_cmd_decoder.sv
/*
  debug side command decoder, clk2 domain
  each request is a one cycle pulse, one clk2 cycle after cmd_valid
  commands must be spaced at least two clk2 cycles apart
  cmd_err is sticky and records illegal opcodes only
*/
`timescale 1ns/1ns
`default_nettype none

module had_cmd_decoder (
  input  logic             clk2,
  input  logic             rst2_b,
  input  logic             cmd_valid,
  input  had_pkg::had_cmd_t cmd,
  output logic             halt_req,
  output logic             resume_req,
  output logic             step_req,
  output logic             clear_req,
  output logic             cmd_err
);

  import had_pkg::*;

  // ==================================================
  // request pulses
  // ==================================================
  // every request drops again on the next edge
  // unless a new strobe arrives
  always_ff @(posedge clk2 or negedge rst2_b)
  begin
    if (!rst2_b)
    begin
      halt_req   <= 1'b0;
      resume_req <= 1'b0;
      step_req   <= 1'b0;
      clear_req  <= 1'b0;
      cmd_err    <= 1'b0;
    end
    else
    begin
      // default to no request this cycle
      halt_req   <= 1'b0;
      resume_req <= 1'b0;
      step_req   <= 1'b0;
      clear_req  <= 1'b0;
      if (cmd_valid)
      begin
        case (cmd)
          // nop is accepted and does nothing
          cmd_nop:    ;
          cmd_halt:   halt_req   <= 1'b1;
          cmd_resume: resume_req <= 1'b1;
          cmd_step:   step_req   <= 1'b1;
          cmd_clear:
          begin
            // clear wipes the error flag and the step count
            clear_req <= 1'b1;
            cmd_err   <= 1'b0;
          end
          // unnamed opcodes, flag stays set until cmd_clear
          default:    cmd_err    <= 1'b1;
        endcase
      end
    end
  end

  // ==================================================
  // checks
  // ==================================================
  // one strobe decodes to one request, so never two at once
  a_one_request: assert property (
    @(posedge clk2) disable iff (!rst2_b)
    $onehot0({halt_req, resume_req, step_req, clear_req})
  );

endmodule

`default_nettype wire

//--- source/had_ctrl_fsm.sv
/*
  core side debug state machine, clk1 domain
  pulses that the current state does not accept are dropped
  a step waits for exactly one core_retire, later retires are ignored
  core_halt, halted_clk1 and step_toggle are flops, safe to cross domains
*/
`timescale 1ns/1ns
`default_nettype none

module had_ctrl_fsm (
  input  logic clk1,
  input  logic rst1_b,
  input  logic halt_pulse,
  input  logic resume_pulse,
  input  logic step_pulse,
  input  logic core_idle,
  input  logic core_retire,
  output logic core_halt,
  output logic halted_clk1,
  output logic step_toggle
);

  import had_pkg::*;

  had_state_t state;
  had_state_t state_nxt;
  // high on the edge where a step retires its instruction
  logic       step_done;

  // ==================================================
  // next state
  // ==================================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_running:
      begin
        // only a halt request matters while running
        if (halt_pulse)
          state_nxt = st_halting;
      end
      st_halting:
      begin
        // wait for the core to drain
        if (core_idle)
          state_nxt = st_halted;
      end
      st_halted:
      begin
        // step wins if both arrive, they cannot in practice
        if (step_pulse)
          state_nxt = st_stepping;
        else if (resume_pulse)
          state_nxt = st_running;
      end
      st_stepping:
      begin
        // first retirement ends the step
        if (core_retire)
          state_nxt = st_halted;
      end
      default: state_nxt = st_running;
    endcase
  end

  assign step_done = (state == st_stepping) && core_retire;

  // ==================================================
  // state and output flops
  // ==================================================
  always_ff @(posedge clk1 or negedge rst1_b)
  begin
    if (!rst1_b)
      state <= st_running;
    else
      state <= state_nxt;
  end

  // outputs follow the next state, so they change on the same edge as state
  always_ff @(posedge clk1 or negedge rst1_b)
  begin
    if (!rst1_b)
    begin
      core_halt   <= 1'b0;
      halted_clk1 <= 1'b0;
    end
    else
    begin
      // halt held while draining and while parked
      core_halt   <= (state_nxt == st_halting) || (state_nxt == st_halted);
      halted_clk1 <= (state_nxt == st_halted);
    end
  end

  // one inversion per completed step, counted on the clk2 side
  always_ff @(posedge clk1 or negedge rst1_b)
  begin
    if (!rst1_b)
      step_toggle <= 1'b0;
    else if (step_done)
      step_toggle <= ~step_toggle;
  end

  // ==================================================
  // checks
  // ==================================================
  // the core is never held while running freely
  a_run_no_halt: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    (state == st_running) |-> !core_halt
  );

  // status level reports halted only when parked
  a_halted_level: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    halted_clk1 |-> (state == st_halted)
  );

  // a toggle marks the return from stepping and nothing else
  a_toggle_on_step: assert property (
    @(posedge clk1) disable iff (!rst1_b)
    !$stable(step_toggle) |-> ($past(state) == st_stepping) && (state == st_halted)
  );

endmodule

`default_nettype wire

//--- source/had_debug_top.sv
/*
  debug subsystem top level
  clk2 must be the slower clock, commands at least two clk2 cycles apart
  no handshake, requests that the state does not accept are dropped
*/
`timescale 1ns/1ns
`default_nettype none

`include "had_settings.svh"

module had_debug_top (
  input  logic                       clk1,
  input  logic                       clk2,
  input  logic                       rst1_b,
  input  logic                       rst2_b,
  // debug side, clk2
  input  logic                       cmd_valid,
  input  logic [`HAD_CMD_W-1:0]      cmd,
  output logic                       halted,
  output logic [`HAD_STEP_CNT_W-1:0] step_count,
  output logic                       cmd_err,
  // core side, clk1
  output logic                       core_halt,
  input  logic                       core_idle,
  input  logic                       core_retire
);

  import had_pkg::*;

  // raw opcode bits seen as the command type, illegal codes pass through
  had_cmd_t cmd_op;
  logic     halt_req;
  logic     resume_req;
  logic     step_req;
  logic     clear_req;
  logic     halt_pulse;
  logic     resume_pulse;
  logic     step_pulse;
  logic     halted_clk1;
  logic     step_toggle;

  assign cmd_op = had_cmd_t'(cmd);

  // ==================================================
  // input side
  // ==================================================
  had_cmd_decoder cmd_decoder_inst (
    .clk2      (clk2),
    .rst2_b    (rst2_b),
    .cmd_valid (cmd_valid),
    .cmd       (cmd_op),
    .halt_req  (halt_req),
    .resume_req(resume_req),
    .step_req  (step_req),
    .clear_req (clear_req),
    .cmd_err   (cmd_err)
  );

  // ==================================================
  // crossing into clk1 and control
  // ==================================================
  ct_had_sync_3flop halt_sync_inst (.clk1(clk1), .clk2(clk2), .rst1_b(rst1_b),
    .rst2_b(rst2_b), .sync_in(halt_req), .sync_out(halt_pulse));
  ct_had_sync_3flop resume_sync_inst (.clk1(clk1), .clk2(clk2), .rst1_b(rst1_b),
    .rst2_b(rst2_b), .sync_in(resume_req), .sync_out(resume_pulse));
  ct_had_sync_3flop step_sync_inst (.clk1(clk1), .clk2(clk2), .rst1_b(rst1_b),
    .rst2_b(rst2_b), .sync_in(step_req), .sync_out(step_pulse));

  had_ctrl_fsm ctrl_fsm_inst (
    .clk1        (clk1),
    .rst1_b      (rst1_b),
    .halt_pulse  (halt_pulse),
    .resume_pulse(resume_pulse),
    .step_pulse  (step_pulse),
    .core_idle   (core_idle),
    .core_retire (core_retire),
    .core_halt   (core_halt),
    .halted_clk1 (halted_clk1),
    .step_toggle (step_toggle)
  );

  // ==================================================
  // output side
  // ==================================================
  had_status_return status_return_inst (
    .clk2       (clk2),
    .rst2_b     (rst2_b),
    .halted_clk1(halted_clk1),
    .step_toggle(step_toggle),
    .clear_req  (clear_req),
    .halted     (halted),
    .step_count (step_count)
  );

endmodule

`default_nettype wire

//--- source/had_pkg.sv
/*
  types of the debug subsystem
  opcodes 5 to 7 have no name and count as illegal commands
  the state enum is read by the control FSM and its assertions only
*/
`default_nettype none

package had_pkg;

`include "had_settings.svh"

  // ==================================================
  // debug side command opcodes
  // ==================================================
  typedef enum logic [`HAD_CMD_W-1:0] {
    cmd_nop    = 3'd0,
    cmd_halt   = 3'd1,
    cmd_resume = 3'd2,
    cmd_step   = 3'd3,
    cmd_clear  = 3'd4
  } had_cmd_t;

  // ==================================================
  // core side debug states
  // ==================================================
  // running   core executes freely, no halt request
  // halting   halt asserted, waiting for the core to go idle
  // halted    core parked, step or resume accepted
  // stepping  halt released until one instruction retires
  typedef enum logic [1:0] {
    st_running  = 2'd0,
    st_halting  = 2'd1,
    st_halted   = 2'd2,
    st_stepping = 2'd3
  } had_state_t;

endpackage

`default_nettype wire

//--- source/had_settings.svh
/*
  widths shared by the debug subsystem
  step counter width may change, any value of 2 or more works
  the counter wraps and never saturates
*/
`ifndef HAD_SETTINGS_SVH
`define HAD_SETTINGS_SVH

// opcode field carried on the debug side command port
`define HAD_CMD_W 3

// ==================================================
// status return
// ==================================================
// wrapping count of completed single steps
`define HAD_STEP_CNT_W 8

`endif

//--- source/had_status_return.sv
/*
  status return from clk1 to clk2
  halted_clk1 and step_toggle must be flop outputs in clk1
  step_toggle may change at most once per two clk2 cycles
  step_count wraps, clear_req wins over a step seen in the same cycle
*/
`timescale 1ns/1ns
`default_nettype none

`include "had_settings.svh"

module had_status_return (
  input  logic                       clk2,
  input  logic                       rst2_b,
  input  logic                       halted_clk1,
  input  logic                       step_toggle,
  input  logic                       clear_req,
  output logic                       halted,
  output logic [`HAD_STEP_CNT_W-1:0] step_count
);

  logic halted_ff1;
  logic toggle_ff1;
  logic toggle_ff2;
  // previous synchronized toggle, for the edge detector
  logic toggle_ff3;
  logic step_seen;

  // ==================================================
  // level synchronizers
  // ==================================================
  always_ff @(posedge clk2 or negedge rst2_b)
  begin
    if (!rst2_b)
    begin
      halted_ff1 <= 1'b0;
      halted     <= 1'b0;
      toggle_ff1 <= 1'b0;
      toggle_ff2 <= 1'b0;
      toggle_ff3 <= 1'b0;
    end
    else
    begin
      halted_ff1 <= halted_clk1;
      halted     <= halted_ff1;
      toggle_ff1 <= step_toggle;
      toggle_ff2 <= toggle_ff1;
      toggle_ff3 <= toggle_ff2;
    end
  end

  // either edge of the toggle is one completed step
  assign step_seen = toggle_ff2 ^ toggle_ff3;

  // ==================================================
  // step counter
  // ==================================================
  always_ff @(posedge clk2 or negedge rst2_b)
  begin
    if (!rst2_b)
      step_count <= '0;
    else if (clear_req)
      step_count <= '0;
    else if (step_seen)
      step_count <= step_count + 1'b1;
  end

  a_count_step: assert property (
    @(posedge clk2) disable iff (!rst2_b)
    !$past(clear_req) |->
      (step_count == $past(step_count)) || (step_count == $past(step_count) + 1'b1)
  );

endmodule

`default_nettype wire
